//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = icache_top.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic     clock_i,
    input  logic     reset_i,
    cache_way_if.way port_i
);
    import icache_pkg::*;

    logic [NUM_SETS-1:0] valid_q;
    logic [TAG_W-1:0]    tag_mem  [NUM_SETS];
    logic [LINE_W-1:0]   line_mem [NUM_SETS];

    // valid bits in flops so the way comes out of reset empty
    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            valid_q            <= '0;
            port_i.valid_rdata <= 1'b0;
        end else if (port_i.en) begin
            port_i.valid_rdata <= valid_q[port_i.index];
            if (port_i.we) begin
                valid_q[port_i.index] <= port_i.valid_wdata;
            end
        end
    end

    // tag and line arrays, synchronous read
    always_ff @(posedge clock_i) begin
        if (port_i.en) begin
            port_i.tag_rdata  <= tag_mem[port_i.index];
            port_i.line_rdata <= line_mem[port_i.index];
            if (port_i.we) begin
                tag_mem[port_i.index] <= port_i.tag_wdata;
                // invalidate writes leave the line as it was
                if (port_i.valid_wdata) begin
                    line_mem[port_i.index] <= port_i.line_wdata;
                end
            end
        end
    end

endmodule

//--- hdl/cache_way_if.sv
`timescale 1ns/1ps

interface cache_way_if;
    import icache_pkg::*;

    // request side
    logic               en;
    logic               we;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0]   tag_wdata;
    logic               valid_wdata;
    logic [LINE_W-1:0]  line_wdata;

    // read data, one cycle after en
    logic [TAG_W-1:0]   tag_rdata;
    logic               valid_rdata;
    logic [LINE_W-1:0]  line_rdata;

    modport ctrl (
        output en, we, index, tag_wdata, valid_wdata, line_wdata,
        input  tag_rdata, valid_rdata, line_rdata
    );

    modport way (
        input  en, we, index, tag_wdata, valid_wdata, line_wdata,
        output tag_rdata, valid_rdata, line_rdata
    );

endinterface

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                          clock_i,
    input  logic                          reset_i,
    // cpu fetch
    input  logic                          valid_i,
    output logic                          ready_o,
    input  icache_pkg::icache_addr_u      addr_i,
    input  logic                          uncached_i,
    output logic                          rvalid_o,
    output logic [icache_pkg::LINE_W-1:0] rdata_o,
    // cache operations
    input  logic                          cacop_en_i,
    input  logic [1:0]                    cacop_code_i,
    input  icache_pkg::icache_addr_u      cacop_addr_i,
    // bus bridge
    output logic                          rd_req_o,
    output logic [31:0]                   rd_addr_o,
    input  logic                          rd_rdy_i,
    input  logic                          ret_valid_i,
    input  logic                          ret_last_i,
    input  logic [icache_pkg::WORD_W-1:0] ret_data_i,
    // way ports
    cache_way_if.ctrl                     way0_o,
    cache_way_if.ctrl                     way1_o
);
    import icache_pkg::*;

    logic [2:0]          state_q;
    logic [TAG_W-1:0]    req_tag_q;
    logic [INDEX_W-1:0]  req_index_q;
    logic                req_uncached_q;
    logic [WAY_W-1:0]    req_way_q;
    logic [NUM_WAYS-1:0] valid_seen_q;

    logic [NUM_WAYS-1:0] way_valid;
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_en;
    logic [NUM_WAYS-1:0] way_we;
    logic [TAG_W-1:0]    way_tag  [NUM_WAYS];
    logic [LINE_W-1:0]   way_line [NUM_WAYS];
    logic [LINE_W-1:0]   hit_line;
    logic [INDEX_W-1:0]  way_index;
    logic [WAY_W-1:0]    victim_way;
    logic [LINE_W-1:0]   refill_line;
    logic                refill_done;

    wire st_idle    = state_q == ST_IDLE;
    wire st_lookup  = state_q == ST_LOOKUP;
    wire st_request = state_q == ST_REQUEST;
    wire st_receive = state_q == ST_RECEIVE;
    wire st_cacop   = state_q == ST_CACOP;

    // a cacop beats a fetch offered in the same cycle
    wire accept_cacop = st_idle && cacop_en_i;
    wire accept_fetch = st_idle && valid_i && !cacop_en_i;
    wire cacop_index_op = accept_cacop &&
        (cacop_code_i == CACOP_INDEX_INIT || cacop_code_i == CACOP_INDEX_INVAL);
    wire cacop_hit_op = accept_cacop && cacop_code_i == CACOP_HIT_INVAL;

    wire any_hit      = |way_hit;
    wire lookup_hit   = st_lookup && any_hit;
    wire refill_start = st_request && rd_rdy_i;
    wire finish       = st_receive && refill_done;
    wire refill_write = finish && !req_uncached_q;
    wire [WAY_W-1:0] hit_way = WAY_W'(way_hit[1]);

    assign way_valid   = {way1_o.valid_rdata, way0_o.valid_rdata};
    assign way_tag[0]  = way0_o.tag_rdata;
    assign way_tag[1]  = way1_o.tag_rdata;
    assign way_line[0] = way0_o.line_rdata;
    assign way_line[1] = way1_o.line_rdata;

    // tag compare and hit line select
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            way_hit[i] = way_valid[i] && way_tag[i] == req_tag_q;
            hit_line   = hit_line | ({LINE_W{way_hit[i]}} & way_line[i]);
        end
    end

    assign ready_o   = st_idle;
    assign rvalid_o  = lookup_hit || finish;
    assign rdata_o   = st_lookup ? hit_line : refill_line;
    assign rd_req_o  = st_request;
    assign rd_addr_o = {req_tag_q, req_index_q, OFFSET_W'(0)};

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            state_q        <= ST_IDLE;
            req_uncached_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (cacop_hit_op) begin
                        state_q <= ST_CACOP;
                    end else if (accept_fetch) begin
                        state_q <= uncached_i ? ST_REQUEST : ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state_q <= any_hit ? ST_IDLE : ST_REQUEST;
                end
                ST_REQUEST: begin
                    if (rd_rdy_i) begin
                        state_q <= ST_RECEIVE;
                    end
                end
                ST_RECEIVE: begin
                    if (refill_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
            if (accept_fetch) begin
                req_uncached_q <= uncached_i;
            end
        end
    end

    // request buffer payload
    always_ff @(posedge clock_i) begin
        if (cacop_hit_op) begin
            req_tag_q   <= cacop_addr_i.cacop.tag;
            req_index_q <= cacop_addr_i.cacop.index;
        end else if (accept_fetch) begin
            req_tag_q   <= addr_i.fetch.tag;
            req_index_q <= addr_i.fetch.index;
        end
        if (st_lookup) begin
            valid_seen_q <= way_valid;
        end
        // victim is fixed once the bus accepts the read
        if (refill_start) begin
            req_way_q <= victim_way;
        end
    end

    // way enables: index ops, hit invalidate, refill and lookup reads
    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            way_we[i] = (cacop_index_op && cacop_addr_i.cacop.way == WAY_W'(i))
                     || (st_cacop && way_hit[i])
                     || (refill_write && req_way_q == WAY_W'(i));
            way_en[i] = way_we[i] || cacop_hit_op || (accept_fetch && !uncached_i);
        end
    end

    assign way_index = !st_idle ? req_index_q :
                       cacop_en_i ? cacop_addr_i.cacop.index : addr_i.fetch.index;

    assign way0_o.en          = way_en[0];
    assign way0_o.we          = way_we[0];
    assign way0_o.index       = way_index;
    assign way0_o.tag_wdata   = req_tag_q;
    assign way0_o.valid_wdata = st_receive;
    assign way0_o.line_wdata  = refill_line;

    assign way1_o.en          = way_en[1];
    assign way1_o.we          = way_we[1];
    assign way1_o.index       = way_index;
    assign way1_o.tag_wdata   = req_tag_q;
    assign way1_o.valid_wdata = st_receive;
    assign way1_o.line_wdata  = refill_line;

    refill_buffer u_refill (
        .clock_i     (clock_i),
        .reset_i     (reset_i),
        .start_i     (refill_start),
        .ret_valid_i (ret_valid_i),
        .ret_last_i  (ret_last_i),
        .ret_data_i  (ret_data_i),
        .done_o      (refill_done),
        .line_o      (refill_line)
    );

    lru_table u_lru (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .touch_i        (lookup_hit || refill_write),
        .touch_index_i  (req_index_q),
        .touch_way_i    (st_lookup ? hit_way : req_way_q),
        .victim_index_i (req_index_q),
        .valid_ways_i   (valid_seen_q),
        .victim_way_o   (victim_way)
    );

endmodule

//--- hdl/icache_pkg.sv
package icache_pkg;

    // address split: tag | index | offset
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;

    // geometry
    localparam int NUM_SETS = 256;
    localparam int NUM_WAYS = 2;
    localparam int WAY_W    = 1;

    // bus beat and line sizes
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int BEATS_PER_LINE = 4;

    // cacop codes, taken from code[4:3] of the instruction
    localparam logic [1:0] CACOP_INDEX_INIT  = 2'd0;
    localparam logic [1:0] CACOP_INDEX_INVAL = 2'd1;
    localparam logic [1:0] CACOP_HIT_INVAL   = 2'd2;

    // controller states
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_REQUEST = 3'd2;
    localparam logic [2:0] ST_RECEIVE = 3'd3;
    localparam logic [2:0] ST_CACOP   = 3'd4;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_view_t;

    // index ops pick the way with address bit 0
    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        logic [2:0]         pad;
        logic [WAY_W-1:0]   way;
    } cacop_view_t;

    typedef union packed {
        fetch_view_t fetch;
        cacop_view_t cacop;
    } icache_addr_u;

endpackage

//--- hdl/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clock,
    input  logic                          reset,
    // cpu fetch
    input  logic                          valid_i,
    output logic                          ready_o,
    input  logic [31:0]                   addr_i,
    input  logic                          uncached_i,
    output logic                          rvalid_o,
    output logic [icache_pkg::LINE_W-1:0] rdata_o,
    // cache operations
    input  logic                          cacop_en_i,
    input  logic [1:0]                    cacop_code_i,
    input  logic [31:0]                   cacop_addr_i,
    // bus bridge
    output logic                          rd_req_o,
    output logic [31:0]                   rd_addr_o,
    input  logic                          rd_rdy_i,
    input  logic                          ret_valid_i,
    input  logic                          ret_last_i,
    input  logic [icache_pkg::WORD_W-1:0] ret_data_i
);

    cache_way_if u_way0_if ();
    cache_way_if u_way1_if ();

    icache_ctrl u_ctrl (
        .clock_i      (clock),
        .reset_i      (reset),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .addr_i       (addr_i),
        .uncached_i   (uncached_i),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o),
        .cacop_en_i   (cacop_en_i),
        .cacop_code_i (cacop_code_i),
        .cacop_addr_i (cacop_addr_i),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .rd_rdy_i     (rd_rdy_i),
        .ret_valid_i  (ret_valid_i),
        .ret_last_i   (ret_last_i),
        .ret_data_i   (ret_data_i),
        .way0_o       (u_way0_if.ctrl),
        .way1_o       (u_way1_if.ctrl)
    );

    // two identical ways
    cache_way u_way0 (
        .clock_i (clock),
        .reset_i (reset),
        .port_i  (u_way0_if.way)
    );

    cache_way u_way1 (
        .clock_i (clock),
        .reset_i (reset),
        .port_i  (u_way1_if.way)
    );

endmodule

//--- hdl/lru_table.sv
`timescale 1ns/1ps

module lru_table (
    input  logic                            clock_i,
    input  logic                            reset_i,
    input  logic                            touch_i,
    input  logic [icache_pkg::INDEX_W-1:0]  touch_index_i,
    input  logic [icache_pkg::WAY_W-1:0]    touch_way_i,
    input  logic [icache_pkg::INDEX_W-1:0]  victim_index_i,
    input  logic [icache_pkg::NUM_WAYS-1:0] valid_ways_i,
    output logic [icache_pkg::WAY_W-1:0]    victim_way_o
);
    import icache_pkg::*;

    // last used way per set
    logic [WAY_W-1:0] last_way_q [NUM_SETS];

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            last_way_q <= '{default: '0};
        end else if (touch_i) begin
            last_way_q[touch_index_i] <= touch_way_i;
        end
    end

    // fill empty ways first, otherwise evict the older one
    always_comb begin
        if (!valid_ways_i[0]) begin
            victim_way_o = WAY_W'(0);
        end else if (!valid_ways_i[1]) begin
            victim_way_o = WAY_W'(1);
        end else begin
            victim_way_o = ~last_way_q[victim_index_i];
        end
    end

endmodule

//--- hdl/refill_buffer.sv
`timescale 1ns/1ps

module refill_buffer (
    input  logic                          clock_i,
    input  logic                          reset_i,
    input  logic                          start_i,
    input  logic                          ret_valid_i,
    input  logic                          ret_last_i,
    input  logic [icache_pkg::WORD_W-1:0] ret_data_i,
    output logic                          done_o,
    output logic [icache_pkg::LINE_W-1:0] line_o
);
    import icache_pkg::*;

    // beats 0..2 are held, the last one comes straight from the bus
    logic [WORD_W-1:0] beat_q [BEATS_PER_LINE-1];
    logic [1:0]        count_q;

    assign done_o = ret_valid_i && (ret_last_i || count_q == 2'(BEATS_PER_LINE - 1));
    assign line_o = {ret_data_i, beat_q[2], beat_q[1], beat_q[0]};

    always_ff @(posedge clock_i) begin
        if (reset_i || start_i) begin
            count_q <= 2'd0;
        end else if (ret_valid_i && !done_o) begin
            count_q <= count_q + 2'd1;
        end
    end

    always_ff @(posedge clock_i) begin
        if (ret_valid_i && !done_o) begin
            beat_q[count_q] <= ret_data_i;
        end
    end

endmodule

//--- icache_top.f
hdl/icache_pkg.sv
hdl/cache_way_if.sv
hdl/cache_way.sv
hdl/refill_buffer.sv
hdl/lru_table.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

//--- testbench/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions (
    input logic        clock_i,
    input logic        reset_i,
    input logic        ready_i,
    input logic        rvalid_i,
    input logic        rd_req_i,
    input logic        rd_rdy_i,
    input logic [31:0] rd_addr_i
);

    // bus request holds until the bridge takes it
    assert property (@(posedge clock_i) disable iff (reset_i)
        rd_req_i && !rd_rdy_i |=> rd_req_i && $stable(rd_addr_i))
        else $error("rd_req or rd_addr changed before rd_rdy");

    assert property (@(posedge clock_i) disable iff (reset_i) !(rvalid_i && ready_i))
        else $error("rvalid and ready high together");

    assert property (@(posedge clock_i) disable iff (reset_i) !(rvalid_i && rd_req_i))
        else $error("rvalid and rd_req high together");

    assert property (@(posedge clock_i) reset_i |=> !rd_req_i)
        else $error("rd_req high right after reset");

endmodule

bind icache_top icache_assertions u_assertions (
    .clock_i   (clock),
    .reset_i   (reset),
    .ready_i   (ready_o),
    .rvalid_i  (rvalid_o),
    .rd_req_i  (rd_req_o),
    .rd_rdy_i  (rd_rdy_i),
    .rd_addr_i (rd_addr_o)
);

//--- testbench/icache_input.txt
# kind (F cached fetch, U uncached fetch, C cacop)  address (hex)  cacop code
# expected bus read (1 read, 0 none); lines A, B, C below share index 0x04
F 10000040 0 1
F 10000048 0 0
U 00005080 0 1
F 00005080 0 1
F 00005084 0 0
F 20000040 0 1
F 10000040 0 0
F 30000040 0 1
F 10000044 0 0
F 20000040 0 1
C 10000040 1 0
F 10000040 0 1
C 00000041 0 0
F 20000040 0 1
C 20000040 2 0
F 20000040 0 1
C 70000040 2 0
F 20000048 0 0
F 1000004c 0 0
C 10000040 3 0
F 10000040 0 0

//--- testbench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;
    import icache_pkg::*;

    logic              clock;
    logic              reset;
    logic              valid_i;
    logic              ready_o;
    logic [31:0]       addr_i;
    logic              uncached_i;
    logic              rvalid_o;
    logic [LINE_W-1:0] rdata_o;
    logic              cacop_en_i;
    logic [1:0]        cacop_code_i;
    logic [31:0]       cacop_addr_i;
    logic              rd_req_o;
    logic [31:0]       rd_addr_o;
    logic              rd_rdy_i;
    logic              ret_valid_i;
    logic              ret_last_i;
    logic [WORD_W-1:0] ret_data_i;

    integer      seed = 32'h95d3bde6;
    byte         op_kind [$];
    logic [31:0] op_addr [$];
    logic [1:0]  op_code [$];
    bit          op_read [$];
    bit          ops_loaded = 1'b0;
    int          test_errors;
    int          pass_count;
    int          fail_count;

    icache_top u_dut (.*);

    always #20 clock = ~clock;

    // beat k of a line from the bridge is its address xor k * 0x11111111
    function automatic logic [WORD_W-1:0] beat_word(input logic [31:0] base, input int k);
        return base ^ (32'h11111111 * 32'(k));
    endfunction

    // fetch view with the byte offset cleared
    function automatic logic [31:0] line_address(input logic [31:0] addr);
        icache_addr_u fetch_addr;
        fetch_addr              = addr;
        fetch_addr.fetch.offset = '0;
        return fetch_addr;
    endfunction

    function automatic logic [LINE_W-1:0] model_line(input logic [31:0] addr);
        logic [31:0] base;
        base = line_address(addr);
        return {beat_word(base, 3), beat_word(base, 2), beat_word(base, 1), beat_word(base, 0)};
    endfunction

    task automatic flag_error(input string what);
        $display("[FAIL] at %0d ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic load_ops();
        int          fd;
        string       line;
        byte         kind;
        logic [31:0] addr;
        logic [1:0]  code;
        bit          expect_read;
        fd = $fopen("testbench/icache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open testbench/icache_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // lines starting with # are comments
                if (line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%c %h %d %d", kind, addr, code, expect_read) == 4) begin
                        op_kind.push_back(kind);
                        op_addr.push_back(addr);
                        op_code.push_back(code);
                        op_read.push_back(expect_read);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_fetch(input bit uncached, input logic [31:0] addr, input bit expect_read);
        int                cycles;
        bit                saw_req;
        bit                done;
        logic [31:0]       req_addr;
        logic [LINE_W-1:0] line;
        cycles   = 0;
        saw_req  = 1'b0;
        done     = 1'b0;
        req_addr = '0;
        line     = '0;
        valid_i    = 1'b1;
        addr_i     = addr;
        uncached_i = uncached;
        @(posedge clock);
        if (!ready_o) flag_error("fetch offered while ready was low");
        #2 valid_i = 1'b0;
        while (!done) begin
            @(posedge clock);
            cycles++;
            if (ready_o) flag_error("ready high before the fetch completed");
            if (rd_req_o) begin
                saw_req  = 1'b1;
                req_addr = rd_addr_o;
            end
            if (rvalid_o) begin
                done = 1'b1;
                line = rdata_o;
            end
        end
        #2;
        if (saw_req != expect_read) begin
            flag_error($sformatf("bus read seen %0d, expected %0d", saw_req, expect_read));
        end
        if (saw_req && req_addr != line_address(addr)) begin
            flag_error($sformatf("rd_addr %h, expected %h", req_addr, line_address(addr)));
        end
        if (line != model_line(addr)) begin
            flag_error($sformatf("rdata %h, expected %h", line, model_line(addr)));
        end
        if (!expect_read && cycles != 1) begin
            flag_error($sformatf("hit returned after %0d cycles instead of 1", cycles));
        end
    endtask

    task automatic run_cacop(input logic [1:0] code, input logic [31:0] addr);
        cacop_en_i   = 1'b1;
        cacop_code_i = code;
        cacop_addr_i = addr;
        @(posedge clock);
        if (!ready_o) flag_error("cache operation offered while ready was low");
        #2 cacop_en_i = 1'b0;
        // hit invalidate spends one cycle comparing tags
        if (code == CACOP_HIT_INVAL) begin
            if (ready_o) flag_error("ready stayed high during hit invalidate");
            @(posedge clock);
            #2;
        end
        if (!ready_o) flag_error("ready low after the cache operation");
    endtask

    initial begin : watchdog
        wait (ops_loaded);
        repeat (op_kind.size() * 100) @(posedge clock);
        $display("timeout: the tests did not finish in %0d cycles", op_kind.size() * 100);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : bridge_model
        logic [31:0] base;
        int          delay;
        int          gap;
        forever begin
            @(posedge clock);
            if (rd_req_o && !reset) begin
                base  = rd_addr_o;
                delay = {$random(seed)} % 4;
                repeat (delay) @(posedge clock);
                #2 rd_rdy_i = 1'b1;
                @(posedge clock);
                #2 rd_rdy_i = 1'b0;
                for (int k = 0; k < BEATS_PER_LINE; k++) begin
                    gap = {$random(seed)} % 3;
                    repeat (gap) begin
                        @(posedge clock);
                        #2;
                    end
                    ret_valid_i = 1'b1;
                    ret_last_i  = (k == BEATS_PER_LINE - 1);
                    ret_data_i  = beat_word(base, k);
                    @(posedge clock);
                    #2 ret_valid_i = 1'b0;
                    ret_last_i = 1'b0;
                end
            end
        end
    end

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        valid_i      = 1'b0;
        addr_i       = '0;
        uncached_i   = 1'b0;
        cacop_en_i   = 1'b0;
        cacop_code_i = '0;
        cacop_addr_i = '0;
        rd_rdy_i     = 1'b0;
        ret_valid_i  = 1'b0;
        ret_last_i   = 1'b0;
        ret_data_i   = '0;
        pass_count   = 0;
        fail_count   = 0;
        load_ops();
        ops_loaded = 1'b1;
        if (op_kind.size() == 0) begin
            $display("no operations were read from the data file");
            fail_count++;
        end
        repeat (3) @(posedge clock);
        #2 reset = 1'b0;
        test_errors = 0;
        if (!ready_o || rvalid_o || rd_req_o) flag_error("outputs wrong after reset");
        for (int i = 0; i < op_kind.size(); i++) begin
            if (op_kind[i] == "C") begin
                run_cacop(op_code[i], op_addr[i]);
            end else begin
                run_fetch(op_kind[i] == "U", op_addr[i], op_read[i]);
            end
            if (test_errors == 0) begin
                pass_count++;
                $display("test %0d %c %h: ok", i, op_kind[i], op_addr[i]);
            end else begin
                fail_count++;
                $display("test %0d %c %h: %0d errors", i, op_kind[i], op_addr[i], test_errors);
            end
            test_errors = 0;
        end
        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
